// File: mem_subsys_top.f
rtl/mem_pkg.sv
rtl/mem_bank_decode.sv
rtl/sram_bank.sv
rtl/mem_resp_merge.sv
rtl/mem_subsys_top.sv
testbench/mem_subsys_properties.sv
testbench/mem_subsys_tb.sv

// File: rtl/mem_bank_decode.sv
`timescale 1ns/1ns

module mem_bank_decode import mem_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  addr_t                addr_i,
  input  be_t                  be_i,
  input  data_t                wdata_i,
  input  user_t                wuser_i,
  input  logic                 ext_active_i,
  output logic [NUM_BANKS-1:0] bank_sel_o,
  output logic                 bank_we_o,
  output bank_addr_t           bank_row_o,
  output data_t                data_mask_o,
  output user_t                user_mask_o,
  output data_t                wdata_o,
  output user_t                wuser_o,
  output logic                 rd_valid_o,
  output bank_idx_t            rd_bank_o,
  output logic                 ext_req_o,
  output logic                 ext_we_o,
  output addr_t                ext_addr_o,
  output be_t                  ext_be_o,
  output data_t                ext_wdata_o,
  output user_t                ext_wuser_o
);

  logic       int_req;
  bank_idx_t  req_bank;
  bank_addr_t req_row;
  data_t      req_dmask;
  user_t      req_umask;
  bank_idx_t  bank_q;

  // ------------------------------------------------------------------
  // Address split and write masks
  // ------------------------------------------------------------------
  assign int_req  = req_i & ~ext_active_i;
  assign req_bank = addr_i[OFFS_W +: BANK_SEL_W];
  // Upper address bits dropped, so the banks alias
  assign req_row  = addr_i[OFFS_W + BANK_SEL_W +: BANK_ADDR_W];

  always_comb begin
    for (int b = 0; b < BE_W; b++) begin
      req_dmask[b*BYTE_W +: BYTE_W] = {BYTE_W{be_i[b]}};
    end
  end

  // Tag only written by a full-word write
  assign req_umask = {USER_W{we_i & (&be_i)}};

  // ------------------------------------------------------------------
  // Bank request stage
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bank_sel_o <= '0;
    end else begin
      bank_sel_o <= '0;
      if (int_req) begin
        bank_sel_o[req_bank] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (int_req) begin
      bank_we_o   <= we_i;
      bank_q      <= req_bank;
      bank_row_o  <= req_row;
      data_mask_o <= req_dmask;
      user_mask_o <= req_umask;
      wdata_o     <= wdata_i;
      wuser_o     <= wuser_i;
    end
  end

  // Read tracking, lines up with the bank output register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= (|bank_sel_o) & ~bank_we_o;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_bank_o <= bank_q;
  end

  // ------------------------------------------------------------------
  // External port, combinational pass of the request
  // ------------------------------------------------------------------
  assign ext_req_o   = req_i & ext_active_i;
  assign ext_we_o    = we_i;
  assign ext_addr_o  = addr_i;
  assign ext_be_o    = be_i;
  assign ext_wdata_o = wdata_i;
  assign ext_wuser_o = wuser_i;

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

  // ------------------------------------------------------------------
  // Word and payload widths
  // ------------------------------------------------------------------
  localparam int unsigned DATA_W = 64;
  localparam int unsigned USER_W = 8;
  localparam int unsigned BYTE_W = 8;
  localparam int unsigned BE_W   = DATA_W / BYTE_W;
  localparam int unsigned ADDR_W = 32;

  // ------------------------------------------------------------------
  // Bank geometry
  // ------------------------------------------------------------------
  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_WORDS = 256;

  // Byte offset inside a word, then bank index, then row
  localparam int unsigned OFFS_W      = $clog2(BE_W);
  localparam int unsigned BANK_SEL_W  = $clog2(NUM_BANKS);
  localparam int unsigned BANK_ADDR_W = $clog2(BANK_WORDS);

  // ------------------------------------------------------------------
  // Shared types
  // ------------------------------------------------------------------
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [USER_W-1:0]      user_t;
  typedef logic [BE_W-1:0]        be_t;
  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [BANK_SEL_W-1:0]  bank_idx_t;
  typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

endpackage

// File: rtl/mem_resp_merge.sv
`timescale 1ns/1ns

module mem_resp_merge import mem_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  rd_valid_i,
  input  bank_idx_t             rd_bank_i,
  input  data_t [NUM_BANKS-1:0] bank_rdata_i,
  input  user_t [NUM_BANKS-1:0] bank_ruser_i,
  input  logic                  ext_rvalid_i,
  input  data_t                 ext_rdata_i,
  input  user_t                 ext_ruser_i,
  output logic                  rvalid_o,
  output data_t                 rdata_o,
  output user_t                 ruser_o
);

  logic  int_valid_q;
  data_t int_rdata_q;
  user_t int_ruser_q;

  // ------------------------------------------------------------------
  // Internal response register
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      int_valid_q <= 1'b0;
    end else begin
      int_valid_q <= rd_valid_i;
    end
  end

  // Pick the bank named by the tracked read
  always_ff @(posedge clk_i) begin
    if (rd_valid_i) begin
      int_rdata_q <= bank_rdata_i[rd_bank_i];
      int_ruser_q <= bank_ruser_i[rd_bank_i];
    end
  end

  // ------------------------------------------------------------------
  // Output merge
  // ------------------------------------------------------------------
  // Internal and external responses never overlap, internal wins anyway
  always_comb begin
    if (int_valid_q) begin
      rvalid_o = 1'b1;
      rdata_o  = int_rdata_q;
      ruser_o  = int_ruser_q;
    end else begin
      rvalid_o = ext_rvalid_i;
      rdata_o  = ext_rdata_i;
      ruser_o  = ext_ruser_i;
    end
  end

endmodule

// File: rtl/mem_subsys_top.sv
`timescale 1ns/1ns

module mem_subsys_top import mem_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  // Requester side
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  be_t   be_i,
  input  data_t wdata_i,
  input  user_t wuser_i,
  input  logic  ext_active_i,
  output logic  rvalid_o,
  output data_t rdata_o,
  output user_t ruser_o,
  // External memory port
  output logic  ext_req_o,
  output logic  ext_we_o,
  output addr_t ext_addr_o,
  output be_t   ext_be_o,
  output data_t ext_wdata_o,
  output user_t ext_wuser_o,
  input  logic  ext_rvalid_i,
  input  data_t ext_rdata_i,
  input  user_t ext_ruser_i
);

  logic [NUM_BANKS-1:0]  bank_sel;
  logic                  bank_we;
  bank_addr_t            bank_row;
  data_t                 data_mask;
  user_t                 user_mask;
  data_t                 bank_wdata;
  user_t                 bank_wuser;
  logic                  rd_valid;
  bank_idx_t             rd_bank;
  data_t [NUM_BANKS-1:0] bank_rdata;
  user_t [NUM_BANKS-1:0] bank_ruser;

  // ------------------------------------------------------------------
  // Request decode
  // ------------------------------------------------------------------
  mem_bank_decode mem_bank_decode_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .be_i         (be_i),
    .wdata_i      (wdata_i),
    .wuser_i      (wuser_i),
    .ext_active_i (ext_active_i),
    .bank_sel_o   (bank_sel),
    .bank_we_o    (bank_we),
    .bank_row_o   (bank_row),
    .data_mask_o  (data_mask),
    .user_mask_o  (user_mask),
    .wdata_o      (bank_wdata),
    .wuser_o      (bank_wuser),
    .rd_valid_o   (rd_valid),
    .rd_bank_o    (rd_bank),
    .ext_req_o    (ext_req_o),
    .ext_we_o     (ext_we_o),
    .ext_addr_o   (ext_addr_o),
    .ext_be_o     (ext_be_o),
    .ext_wdata_o  (ext_wdata_o),
    .ext_wuser_o  (ext_wuser_o)
  );

  // ------------------------------------------------------------------
  // Banks, a data array and a tag array each
  // ------------------------------------------------------------------
  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    sram_bank #(
      .word_t (data_t)
    ) data_bank_i (
      .clk_i   (clk_i),
      .cs_i    (bank_sel[i]),
      .we_i    (bank_we),
      .row_i   (bank_row),
      .wmask_i (data_mask),
      .wdata_i (bank_wdata),
      .rdata_o (bank_rdata[i])
    );

    sram_bank #(
      .word_t (user_t)
    ) user_bank_i (
      .clk_i   (clk_i),
      .cs_i    (bank_sel[i]),
      .we_i    (bank_we),
      .row_i   (bank_row),
      .wmask_i (user_mask),
      .wdata_i (bank_wuser),
      .rdata_o (bank_ruser[i])
    );
  end

  // ------------------------------------------------------------------
  // Response merge
  // ------------------------------------------------------------------
  mem_resp_merge mem_resp_merge_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rd_valid_i   (rd_valid),
    .rd_bank_i    (rd_bank),
    .bank_rdata_i (bank_rdata),
    .bank_ruser_i (bank_ruser),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i),
    .ext_ruser_i  (ext_ruser_i),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .ruser_o      (ruser_o)
  );

endmodule

// File: rtl/sram_bank.sv
`timescale 1ns/1ns

module sram_bank import mem_pkg::*; #(
  parameter type word_t = data_t
) (
  input  logic       clk_i,
  input  logic       cs_i,
  input  logic       we_i,
  input  bank_addr_t row_i,
  input  word_t      wmask_i,
  input  word_t      wdata_i,
  output word_t      rdata_o
);

  word_t mem_q [BANK_WORDS];

  // Zero contents at time zero, simulation start only
  initial begin
    for (int i = 0; i < BANK_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  // ------------------------------------------------------------------
  // Bit-masked write port
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (cs_i && we_i) begin
      mem_q[row_i] <= (mem_q[row_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  // ------------------------------------------------------------------
  // Registered read port
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (cs_i && !we_i) begin
      rdata_o <= mem_q[row_i];
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f mem_subsys_top.f \
  --top-module mem_subsys_tb -o mem_subsys_sim &&
./obj_dir/mem_subsys_sim ||
{ echo "Run ended with an error"; exit 1; }

// File: testbench/mem_cases.txt
# name ext op addr be wdata wuser exp_data exp_user (all numbers hex)
# op W writes, R reads and waits for the answer, P reads and moves on
# Full-word write and read back
wr_full     0 W 00000100 ff 1122334455667788 a5 0000000000000000 00
rd_full     0 R 00000100 00 0000000000000000 00 1122334455667788 a5
rd_offset   0 R 00000105 00 0000000000000000 00 1122334455667788 a5
rd_blank    0 R 00000180 00 0000000000000000 00 0000000000000000 00
# Partial writes change enabled bytes only and keep the tag
wr_lo       0 W 00000100 0f aaaaaaaabbbbbbbb 3c 0000000000000000 00
rd_lo       0 R 00000100 00 0000000000000000 00 11223344bbbbbbbb a5
wr_hi       0 W 00000100 f0 ccccccccdddddddd 77 0000000000000000 00
rd_hi       0 R 00000100 00 0000000000000000 00 ccccccccbbbbbbbb a5
wr_b_full   0 W 00000208 ff 0123456789abcdef 11 0000000000000000 00
wr_b_ends   0 W 00000208 81 ffeeddccbbaa9988 22 0000000000000000 00
rd_b_ends   0 R 00000208 00 0000000000000000 00 ff23456789abcd88 11
wr_b_seven  0 W 00000208 7f 0000000000000000 44 0000000000000000 00
rd_b_seven  0 R 00000208 00 0000000000000000 00 ff00000000000000 11
wr_b_retag  0 W 00000208 ff fedcba9876543210 99 0000000000000000 00
rd_b_retag  0 R 00000208 00 0000000000000000 00 fedcba9876543210 99
# Four banks read back to back
wr_bank0    0 W 00000400 ff 1000000000000a00 a0 0000000000000000 00
wr_bank1    0 W 00000408 ff 2000000000000b11 b1 0000000000000000 00
wr_bank2    0 W 00000410 ff 3000000000000c22 c2 0000000000000000 00
wr_bank3    0 W 00000418 ff 4000000000000d33 d3 0000000000000000 00
wr_bank1_b  0 W 00000428 ff 5000000000000e44 e4 0000000000000000 00
rd_bank3    0 P 00000418 00 0000000000000000 00 4000000000000d33 d3
rd_bank1    0 P 00000408 00 0000000000000000 00 2000000000000b11 b1
rd_bank1_b  0 P 00000428 00 0000000000000000 00 5000000000000e44 e4
rd_bank0    0 P 00000400 00 0000000000000000 00 1000000000000a00 a0
rd_bank2    0 R 00000410 00 0000000000000000 00 3000000000000c22 c2
rd_old      0 P 00000400 00 0000000000000000 00 1000000000000a00 a0
wr_new      0 W 00000400 ff 5a5a5a5a5a5a5a5a 5a 0000000000000000 00
rd_new      0 R 00000400 00 0000000000000000 00 5a5a5a5a5a5a5a5a 5a
# Upper address bits alias
wr_alias    0 W 00000600 ff 0f1e2d3c4b5a6978 6d 0000000000000000 00
rd_alias_hi 0 R 80002600 00 0000000000000000 00 0f1e2d3c4b5a6978 6d
wr_alias_hi 0 W 7ffe0600 ff 8796a5b4c3d2e1f0 e1 0000000000000000 00
rd_alias_lo 0 R 00000600 00 0000000000000000 00 8796a5b4c3d2e1f0 e1
# External port, internal memory untouched
ext_wr      1 W 00000100 ff 5555aaaa5555aaaa 3e 0000000000000000 00
ext_rd      1 R 00000100 00 0000000000000000 00 0badc0ffee0ddf00 c7
ext_wr_part 1 W 00000208 0f 1234567812345678 01 0000000000000000 00
ext_rd_b    1 R 00000208 00 0000000000000000 00 0123012301230123 4a
ext_rd_c    1 R 00000418 00 0000000000000000 00 feedfacecafebeef 9d
# Back on the internal memory
rd_int_a    0 R 00000100 00 0000000000000000 00 ccccccccbbbbbbbb a5
rd_int_b    0 P 00000208 00 0000000000000000 00 fedcba9876543210 99
rd_int_c    0 R 00000418 00 0000000000000000 00 4000000000000d33 d3

// File: testbench/mem_subsys_properties.sv
`timescale 1ns/1ns

module mem_subsys_properties import mem_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 req_i,
  input logic                 we_i,
  input logic                 ext_active_i,
  input logic                 ext_req_i,
  input logic                 rvalid_i,
  input logic                 ext_rvalid_i,
  input logic                 rd_valid_i,
  input logic [NUM_BANKS-1:0] bank_sel_i
);

  // ------------------------------------------------------------------
  // External port gating
  // ------------------------------------------------------------------
  // A diverted request needs ext_active_i and never selects a bank
  a_ext_req_gated : assert property (@(posedge clk_i) disable iff (rst_i)
    ext_req_i |=> $past(ext_active_i) && (bank_sel_i == '0))
    else $error("external request without ext_active_i or reaching an internal bank");

  // ------------------------------------------------------------------
  // Internal read latency
  // ------------------------------------------------------------------
  // Merger registers two edges after the sampling edge, seen at the third
  a_read_resp : assert property (@(posedge clk_i) disable iff (rst_i)
    $past(req_i && !we_i && !ext_active_i, 3) |-> rvalid_i)
    else $error("internal read without rvalid_o at the expected edge");

  // Registered internal result pending when rd_valid was high one edge back
  a_no_overlap : assert property (@(posedge clk_i) disable iff (rst_i)
    ext_rvalid_i |-> !$past(rd_valid_i))
    else $error("external response collides with an internal result");

endmodule

// File: testbench/mem_subsys_tb.sv
`timescale 1ns/1ns

module mem_subsys_tb import mem_pkg::*; ();

  logic   clk;
  logic   rst;
  logic   req;
  logic   we;
  addr_t  addr;
  be_t    be;
  data_t  wdata;
  user_t  wuser;
  logic   ext_active;
  logic   rvalid;
  data_t  rdata;
  user_t  ruser;
  logic   ext_req;
  logic   ext_we;
  addr_t  ext_addr;
  be_t    ext_be;
  data_t  ext_wdata;
  user_t  ext_wuser;
  logic   ext_rvalid;
  data_t  ext_rdata;
  user_t  ext_ruser;

  integer seed;
  int     cycle_cnt = 0;

  // Expected responses in request order
  string  exp_name_q[$];
  data_t  exp_data_q[$];
  user_t  exp_user_q[$];
  int     exp_due_q[$];
  // Reply data for the external memory model
  data_t  reply_data_q[$];
  user_t  reply_user_q[$];

  mem_subsys_top mem_subsys_top_i (
    .clk_i        (clk),
    .rst_i        (rst),
    .req_i        (req),
    .we_i         (we),
    .addr_i       (addr),
    .be_i         (be),
    .wdata_i      (wdata),
    .wuser_i      (wuser),
    .ext_active_i (ext_active),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .ruser_o      (ruser),
    .ext_req_o    (ext_req),
    .ext_we_o     (ext_we),
    .ext_addr_o   (ext_addr),
    .ext_be_o     (ext_be),
    .ext_wdata_o  (ext_wdata),
    .ext_wuser_o  (ext_wuser),
    .ext_rvalid_i (ext_rvalid),
    .ext_rdata_i  (ext_rdata),
    .ext_ruser_i  (ext_ruser)
  );

  bind mem_subsys_top mem_subsys_properties mem_subsys_properties_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .ext_active_i (ext_active_i),
    .ext_req_i    (ext_req_o),
    .rvalid_i     (rvalid_o),
    .ext_rvalid_i (ext_rvalid_i),
    .rd_valid_i   (rd_valid),
    .bank_sel_i   (bank_sel)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ------------------------------------------------------------------
  // Checks and failure exits
  // ------------------------------------------------------------------
  task check_value(input string name, input logic [63:0] exp_val, input logic [63:0] act_val);
    if (act_val !== exp_val) begin
      $display("FAIL %s expected %h actual %h", name, exp_val, act_val);
      $display("Simulation FAILED");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  task fail_run(input string what);
    $display("Error: %s", what);
    $display("Simulation FAILED");
    $fatal(1, "%s", what);
  endtask

  task release_request;
    @(posedge clk);
    #1;
    req = 1'b0;
    we  = 1'b0;
  endtask

  // Returns just after a rising edge once every read has answered
  task drain_responses;
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      if (exp_name_q.size() == 0) break;
    end
    if (exp_name_q.size() != 0) fail_run("no read response within 20 cycles");
  endtask

  task run_case(input string name, input logic ext_f, input string op, input addr_t a,
                input be_t b, input data_t wd, input user_t wu, input data_t ed,
                input user_t eu);
    if (op != "W" && op != "R" && op != "P") fail_run("unknown op in case file");
    // Switch only with nothing in flight
    if (ext_f != ext_active) begin
      release_request();
      drain_responses();
      #1;
      ext_active = ext_f;
    end
    @(posedge clk);
    #1;
    req   = 1'b1;
    we    = (op == "W");
    addr  = a;
    be    = b;
    wdata = wd;
    wuser = wu;
    if (op != "W") begin
      exp_name_q.push_back(name);
      exp_data_q.push_back(ed);
      exp_user_q.push_back(eu);
      // Sampled at the next edge, result registered two edges later
      exp_due_q.push_back(ext_f ? -1 : cycle_cnt + 3);
      if (ext_f) begin
        reply_data_q.push_back(ed);
        reply_user_q.push_back(eu);
      end
    end
    if (ext_f) begin
      #1;
      check_value({name, " ext_req_o"}, 64'(1'b1), 64'(ext_req));
      check_value({name, " ext_we_o"}, 64'(op == "W"), 64'(ext_we));
      check_value({name, " ext_addr_o"}, 64'(a), 64'(ext_addr));
      check_value({name, " ext_be_o"}, 64'(b), 64'(ext_be));
      check_value({name, " ext_wdata_o"}, wd, ext_wdata);
      check_value({name, " ext_wuser_o"}, 64'(wu), 64'(ext_wuser));
    end
    if (op == "R") begin
      release_request();
      drain_responses();
    end
  endtask

  // ------------------------------------------------------------------
  // Response monitor
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    string name;
    data_t exp_data;
    user_t exp_user;
    int    due;
    if (!rst && rvalid) begin
      if (exp_name_q.size() == 0) begin
        fail_run("rvalid_o high with no read outstanding");
      end else begin
        name     = exp_name_q.pop_front();
        exp_data = exp_data_q.pop_front();
        exp_user = exp_user_q.pop_front();
        due      = exp_due_q.pop_front();
        check_value(name, exp_data, rdata);
        check_value({name, " tag"}, 64'(exp_user), 64'(ruser));
        if (due >= 0) check_value({name, " cycle"}, 64'(due), 64'(cycle_cnt));
      end
    end
  end

  // External memory, replies after 1 to 4 cycles
  always @(posedge clk) begin
    int unsigned delay;
    if (!rst && ext_req && !ext_we) begin
      if (reply_data_q.size() == 0) begin
        fail_run("external read with no reply data queued");
      end else begin
        delay = 1 + ($unsigned($random(seed)) % 4);
        repeat (delay - 1) @(posedge clk);
        #1;
        ext_rvalid = 1'b1;
        ext_rdata  = reply_data_q.pop_front();
        ext_ruser  = reply_user_q.pop_front();
        @(posedge clk);
        #1;
        ext_rvalid = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------
  // Case file driver
  // ------------------------------------------------------------------
  initial begin
    int    fd;
    int    code;
    int    ext_f;
    string tok;
    string op;
    string rest;
    addr_t addr_f;
    be_t   be_f;
    data_t wdata_f;
    user_t wuser_f;
    data_t exp_data_f;
    user_t exp_user_f;
    seed       = 20;
    rst        = 1'b1;
    req        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    be         = '0;
    wdata      = '0;
    wuser      = '0;
    ext_active = 1'b0;
    ext_rvalid = 1'b0;
    ext_rdata  = '0;
    ext_ruser  = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_value("reset rvalid_o", 64'(1'b0), 64'(rvalid));
    check_value("reset ext_req_o", 64'(1'b0), 64'(ext_req));
    fd = $fopen("testbench/mem_cases.txt", "r");
    if (fd == 0) fail_run("cannot open testbench/mem_cases.txt");
    while (1) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      if (tok.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%d %s %h %h %h %h %h %h", ext_f, op, addr_f, be_f, wdata_f,
                       wuser_f, exp_data_f, exp_user_f);
        if (code != 8) fail_run("malformed line in case file");
        run_case(tok, ext_f != 0, op, addr_f, be_f, wdata_f, wuser_f, exp_data_f,
                 exp_user_f);
      end
    end
    $fclose(fd);
    release_request();
    drain_responses();
    $display("Simulation PASSED");
    $finish;
  end

endmodule
